/* src.f */
+incdir+bench
hw/recovery_pkg.sv
hw/recovery_cmd_decode.sv
hw/recovery_sequencer.sv
hw/recovery_reg_bank.sv
hw/recovery_indirect_fifo.sv
hw/recovery_resp_tx.sv
hw/recovery_executor_top.sv
bench/recovery_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the recovery executor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f src.f --top-module recovery_tb \
    -o recovery_sim; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/recovery_sim)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
  exit 0
fi
exit 1

/* bench/recovery_tb_tests.svh */
// Directed test tasks for the recovery command executor testbench

// Status words are empty/full flags, write index, read index and depth
task automatic expect_fifo_status(input logic empty, input logic full, input int wr_idx,
                                  input int rd_idx, input logic stall);
  read_cmd(CMD_INDIRECT_FIFO_STATUS, stall);
  exp_words.delete();
  exp_words.push_back({30'd0, full, empty});
  exp_words.push_back(32'(wr_idx));
  exp_words.push_back(32'(rd_idx));
  exp_words.push_back(32'(FifoDepth));
  check_response(16'd16);
endtask

// Protocol error code sits in byte 1
task automatic expect_device_status(input logic [7:0] code);
  read_cmd(CMD_DEVICE_STATUS, 1'b0);
  exp_words.delete();
  exp_words.push_back({16'd0, code, 8'd0});
  check_response(16'd4);
endtask

task automatic test_fifo_status_reset();
  begin_test("fifo_status_reset");
  check_eq("cmd_ready_o", 1, cmd_ready_o);
  check_eq("cmd_done_o", 0, cmd_done_o);
  check_eq("wr_ready_o", 0, wr_ready_o);
  check_eq("res_valid_o", 0, res_valid_o);
  check_eq("res_dvalid_o", 0, res_dvalid_o);
  check_eq("res_dlast_o", 0, res_dlast_o);
  check_eq("fifo_rd_valid_o", 0, fifo_rd_valid_o);
  check_eq("payload_available_o", 0, payload_available_o);
  expect_fifo_status(1'b1, 1'b0, 0, 0, 1'b0);
  end_test();
endtask

task automatic test_csr_write_read();
  begin_test("csr_write_read");
  wr_buf.delete();
  wr_buf.push_back(32'h000F_0201);
  write_cmd(CMD_RECOVERY_CTRL, 16'd3);
  check_eq("image_activated_o", 1, image_activated_o);
  read_cmd(CMD_RECOVERY_CTRL, 1'b0);
  exp_words.delete();
  exp_words.push_back(32'h000F_0201);
  check_response(16'd3);
  end_test();
endtask

task automatic test_fifo_data();
  begin_test("fifo_data");
  wr_buf.delete();
  for (int i = 0; i < 4; i++) wr_buf.push_back(next_random());
  write_cmd(CMD_INDIRECT_FIFO_DATA, 16'd16);
  check_eq("payload_available_o", 1, payload_available_o);
  for (int i = 0; i < 4; i++) begin
    pop_check(wr_buf[i]);
    if (i == 0) check_eq("payload_available_o after pop", 0, payload_available_o);
  end
  check_eq("fifo_rd_valid_o when drained", 0, fifo_rd_valid_o);

  // One word more than the FIFO holds
  wr_buf.delete();
  for (int i = 0; i <= FifoDepth; i++) wr_buf.push_back(next_random());
  send_cmd(1'b0, CMD_INDIRECT_FIFO_DATA, 16'((FifoDepth + 1) * 4), 1'b0);
  for (int i = 0; i < FifoDepth; i++) push_word(wr_buf[i]);
  wr_valid_i = 1'b1;
  wr_data_i  = wr_buf[FifoDepth];
  repeat (4) begin
    check_eq("wr_ready_o while full", 0, wr_ready_o);
    step();
  end
  pop_check(wr_buf[0]);
  push_word(wr_buf[FifoDepth]);
  wait_done(HsLimit);
  for (int i = 1; i <= FifoDepth; i++) pop_check(wr_buf[i]);
  end_test();
endtask

task automatic test_fifo_clear();
  begin_test("fifo_clear");
  wr_buf.delete();
  wr_buf.push_back(next_random());
  wr_buf.push_back(next_random());
  write_cmd(CMD_INDIRECT_FIFO_DATA, 16'd8);
  check_eq("fifo_rd_valid_o before clear", 1, fifo_rd_valid_o);
  wr_buf.delete();
  wr_buf.push_back(32'h0000_0100);
  write_cmd(CMD_INDIRECT_FIFO_CTRL, 16'd4);
  check_eq("fifo_rd_valid_o after clear", 0, fifo_rd_valid_o);
  expect_fifo_status(1'b1, 1'b0, 0, 0, 1'b0);
  end_test();
endtask

task automatic test_protocol_errors();
  begin_test("protocol_errors");
  send_cmd(1'b1, CMD_DEVICE_STATUS, 16'd4, 1'b1);
  wait_done(3);
  expect_device_status(8'd4);
  // Rejected write takes no data words
  send_cmd(1'b0, CMD_DEVICE_STATUS, 16'd4, 1'b0);
  wr_valid_i = 1'b1;
  wr_data_i  = next_random();
  step();
  // An accepted write would be taking words by now
  check_eq("wr_ready_o on rejected write", 0, wr_ready_o);
  wait_done(2);
  wr_valid_i = 1'b0;
  expect_device_status(8'd1);
  send_cmd(1'b0, cmd_e'(8'd50), 16'd4, 1'b0);
  wait_done(3);
  expect_device_status(8'd2);
  send_cmd(1'b0, CMD_RECOVERY_CTRL, 16'd4, 1'b0);
  wait_done(3);
  expect_device_status(8'd3);
  end_test();
endtask

task automatic test_read_backpressure();
  logic [7:0] ref_bytes[$];
  begin_test("read_backpressure");
  expect_fifo_status(1'b1, 1'b0, 0, 0, 1'b0);
  ref_bytes = rx_bytes;
  expect_fifo_status(1'b1, 1'b0, 0, 0, 1'b1);
  check_eq("stalled byte count", ref_bytes.size(), rx_bytes.size());
  for (int i = 0; i < ref_bytes.size() && i < rx_bytes.size(); i++) begin
    check_eq($sformatf("stalled byte %0d", i), ref_bytes[i], rx_bytes[i]);
  end
  end_test();
endtask

/* bench/recovery_tb.sv */
// Testbench top: clock, reset, DUT dut0, LCG, watchdog, driver and check helpers, summary
`timescale 1ns/100ps

module recovery_tb;
  import recovery_pkg::*;

  localparam int FifoDepth   = 16;
  localparam int ClkPeriod   = 8;
  localparam int HsLimit     = 64;
  localparam int CycleMargin = 48;
  // Words moved per test, in run order
  localparam int TestWords = 4 + 2 + (8 + 2 * (FifoDepth + 1)) + 7 + 8 + 8;
  localparam int WatchdogCycles = 8 + TestWords * CycleMargin;

  logic        clk_i;
  logic        rst_ni;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  cmd_t        cmd_i;
  logic        cmd_done_o;
  logic        wr_valid_i;
  logic        wr_ready_o;
  logic [31:0] wr_data_i;
  logic        res_valid_o;
  logic        res_ready_i;
  logic [15:0] res_len_o;
  logic        res_dvalid_o;
  logic        res_dready_i;
  logic [7:0]  res_data_o;
  logic        res_dlast_o;
  logic        fifo_rd_valid_o;
  logic        fifo_rd_ready_i;
  logic [31:0] fifo_rd_data_o;
  logic        payload_available_o;
  logic        image_activated_o;

  logic [31:0] lcg_state = 32'h3ce1;
  string       test_name;
  int          test_errors;
  int          error_total;
  int          tests_run;
  int          tests_failed;
  // Words to send, words expected back, bytes received
  logic [31:0] wr_buf[$];
  logic [31:0] exp_words[$];
  logic [7:0]  rx_bytes[$];
  logic [15:0] rx_len;
  int          rx_last;

  recovery_executor_top #(
    .FifoDepth (FifoDepth)
  ) dut0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_ready_o         (cmd_ready_o),
    .cmd_i               (cmd_i),
    .cmd_done_o          (cmd_done_o),
    .wr_valid_i          (wr_valid_i),
    .wr_ready_o          (wr_ready_o),
    .wr_data_i           (wr_data_i),
    .res_valid_o         (res_valid_o),
    .res_ready_i         (res_ready_i),
    .res_len_o           (res_len_o),
    .res_dvalid_o        (res_dvalid_o),
    .res_dready_i        (res_dready_i),
    .res_data_o          (res_data_o),
    .res_dlast_o         (res_dlast_o),
    .fifo_rd_valid_o     (fifo_rd_valid_o),
    .fifo_rd_ready_i     (fifo_rd_ready_i),
    .fifo_rd_data_o      (fifo_rd_data_o),
    .payload_available_o (payload_available_o),
    .image_activated_o   (image_activated_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic random_bit();
    logic [31:0] r;
    r = next_random();
    return r[20];
  endfunction

  // Register bytes go out least significant first
  function automatic logic [7:0] byte_of(logic [31:0] w, int lane);
    return w[8*lane +: 8];
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic fail_note(input string msg);
    $display("%s: %s", test_name, msg);
    test_errors++;
    error_total++;
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Error in %s: %s expected %0h, actual %0h", test_name, what, exp, act);
      test_errors++;
      error_total++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("Test %s: passed", test_name);
    end else begin
      $display("Test %s: failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic send_cmd(input logic rd, input cmd_e code, input logic [15:0] len,
                          input logic err);
    int n;
    n = 0;
    cmd_i.is_rd = rd;
    cmd_i.code  = code;
    cmd_i.len   = len;
    cmd_i.error = err;
    cmd_valid_i = 1'b1;
    while (!cmd_ready_o && n < HsLimit) begin
      step();
      n++;
    end
    assert (cmd_ready_o) else fail_note("command was never accepted");
    step();
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (!cmd_done_o && n < limit) begin
      step();
      n++;
    end
    assert (cmd_done_o) else fail_note($sformatf("no cmd_done_o within %0d cycles", limit));
    step();
  endtask

  task automatic push_word(input logic [31:0] data);
    int n;
    n = 0;
    wr_valid_i = 1'b1;
    wr_data_i  = data;
    while (!wr_ready_o && n < HsLimit) begin
      step();
      n++;
    end
    assert (wr_ready_o) else fail_note("write word was never accepted");
    step();
    wr_valid_i = 1'b0;
  endtask

  task automatic write_cmd(input cmd_e code, input logic [15:0] len);
    send_cmd(1'b0, code, len, 1'b0);
    foreach (wr_buf[i]) push_word(wr_buf[i]);
    wait_done(HsLimit);
  endtask

  task automatic pop_check(input logic [31:0] exp);
    int n;
    n = 0;
    fifo_rd_ready_i = 1'b1;
    while (!fifo_rd_valid_o && n < HsLimit) begin
      step();
      n++;
    end
    assert (fifo_rd_valid_o) else fail_note("FIFO read port never became valid");
    check_eq("fifo_rd_data_o", exp, fifo_rd_data_o);
    step();
    fifo_rd_ready_i = 1'b0;
  endtask

  // Read with optional random stalls on both response handshakes
  task automatic read_cmd(input cmd_e code, input logic stall);
    int n;
    rx_bytes.delete();
    rx_last = -1;
    rx_len  = '0;
    send_cmd(1'b1, code, 16'd0, 1'b0);
    n = 0;
    while (n < HsLimit) begin
      res_ready_i = stall ? random_bit() : 1'b1;
      if (res_valid_o && res_ready_i) break;
      step();
      n++;
    end
    assert (n < HsLimit) else fail_note("read length was never offered");
    rx_len = res_len_o;
    step();
    res_ready_i = 1'b0;
    n = 0;
    while (rx_last < 0 && n < 4 * HsLimit) begin
      res_dready_i = stall ? random_bit() : 1'b1;
      if (res_dvalid_o && res_dready_i) begin
        rx_bytes.push_back(res_data_o);
        if (res_dlast_o) rx_last = rx_bytes.size() - 1;
      end
      step();
      n++;
    end
    res_dready_i = 1'b0;
    assert (rx_last >= 0) else fail_note("read response never marked a last byte");
    wait_done(HsLimit);
  endtask

  task automatic check_response(input logic [15:0] len);
    check_eq("res_len_o", len, rx_len);
    check_eq("byte count", len, rx_bytes.size());
    for (int i = 0; i < rx_bytes.size() && i < len; i++) begin
      check_eq($sformatf("byte %0d", i), byte_of(exp_words[i / 4], i % 4), rx_bytes[i]);
    end
    check_eq("last byte position", len - 1, rx_last);
  endtask

  `include "recovery_tb_tests.svh"

  initial begin
    rst_ni          = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_i           = '0;
    wr_valid_i      = 1'b0;
    wr_data_i       = '0;
    res_ready_i     = 1'b0;
    res_dready_i    = 1'b0;
    fifo_rd_ready_i = 1'b0;
    error_total     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    step();

    test_fifo_status_reset();
    test_csr_write_read();
    test_fifo_data();
    test_fifo_clear();
    test_protocol_errors();
    test_read_backpressure();

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_total);
    if (error_total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* hw/recovery_executor_top.sv */
// Recovery command executor top level: decode, sequencer, registers, FIFO and response
`timescale 1ns/100ps

module recovery_executor_top #(
  parameter int unsigned FifoDepth = 16
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Decoded commands
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  input  recovery_pkg::cmd_t cmd_i,
  output logic               cmd_done_o,
  // Write data words
  input  logic               wr_valid_i,
  output logic               wr_ready_o,
  input  logic [31:0]        wr_data_i,
  // Read response length and bytes
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output logic [15:0]        res_len_o,
  output logic               res_dvalid_o,
  input  logic               res_dready_i,
  output logic [7:0]         res_data_o,
  output logic               res_dlast_o,
  // CSR-side read port of the indirect FIFO
  output logic               fifo_rd_valid_o,
  input  logic               fifo_rd_ready_i,
  output logic [31:0]        fifo_rd_data_o,
  output logic               payload_available_o,
  output logic               image_activated_o
);
  import recovery_pkg::*;

  dec_t                         dec;
  logic                         dec_valid;
  logic                         idle;
  reg_e                         reg_idx;
  logic                         reg_we;
  logic [31:0]                  rd_word;
  proto_err_e                   done_status;
  logic                         fifo_written;
  logic                         fifo_push;
  logic                         fifo_clr;
  logic                         fifo_pop;
  logic                         fifo_empty;
  logic                         fifo_full;
  logic [$clog2(FifoDepth)-1:0] fifo_wr_idx;
  logic [$clog2(FifoDepth)-1:0] fifo_rd_idx;
  logic                         tx_load;
  logic [15:0]                  tx_len;
  logic [15:0]                  tx_words;
  logic                         word_req;

  assign fifo_pop = fifo_rd_valid_o & fifo_rd_ready_i;

  recovery_cmd_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .idle_i      (idle),
    .dec_valid_o (dec_valid),
    .dec_o       (dec)
  );

  recovery_sequencer u_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .dec_valid_i    (dec_valid),
    .dec_i          (dec),
    .wr_valid_i     (wr_valid_i),
    .wr_ready_o     (wr_ready_o),
    .fifo_full_i    (fifo_full),
    .word_req_i     (word_req),
    .idle_o         (idle),
    .reg_idx_o      (reg_idx),
    .reg_we_o       (reg_we),
    .fifo_push_o    (fifo_push),
    .tx_load_o      (tx_load),
    .tx_len_o       (tx_len),
    .tx_words_o     (tx_words),
    .done_o         (cmd_done_o),
    .done_status_o  (done_status),
    .fifo_written_o (fifo_written)
  );

  recovery_reg_bank #(
    .FifoDepth (FifoDepth)
  ) u_reg_bank (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .reg_idx_i           (reg_idx),
    .reg_we_i            (reg_we),
    .wr_data_i           (wr_data_i),
    .done_i              (cmd_done_o),
    .done_status_i       (done_status),
    .fifo_written_i      (fifo_written),
    .fifo_pop_i          (fifo_pop),
    .fifo_empty_i        (fifo_empty),
    .fifo_full_i         (fifo_full),
    .fifo_wr_idx_i       (fifo_wr_idx),
    .fifo_rd_idx_i       (fifo_rd_idx),
    .rd_word_o           (rd_word),
    .fifo_clr_o          (fifo_clr),
    .payload_available_o (payload_available_o),
    .image_activated_o   (image_activated_o)
  );

  recovery_indirect_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (fifo_push),
    .push_data_i (wr_data_i),
    .clr_i       (fifo_clr),
    .pop_valid_o (fifo_rd_valid_o),
    .pop_ready_i (fifo_rd_ready_i),
    .pop_data_o  (fifo_rd_data_o),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full),
    .wr_idx_o    (fifo_wr_idx),
    .rd_idx_o    (fifo_rd_idx)
  );

  recovery_resp_tx u_resp_tx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (tx_load),
    .len_i        (tx_len),
    .words_i      (tx_words),
    .rd_word_i    (rd_word),
    .word_req_o   (word_req),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_len_o    (res_len_o),
    .res_dvalid_o (res_dvalid_o),
    .res_dready_i (res_dready_i),
    .res_data_o   (res_data_o),
    .res_dlast_o  (res_dlast_o)
  );

endmodule

/* hw/recovery_resp_tx.sv */
// Read response length handshake and word to byte serializer with last flag
`timescale 1ns/100ps

module recovery_resp_tx (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        load_i,
  input  logic [15:0] len_i,
  input  logic [15:0] words_i,
  input  logic [31:0] rd_word_i,
  output logic        word_req_o,
  output logic        res_valid_o,
  input  logic        res_ready_i,
  output logic [15:0] res_len_o,
  output logic        res_dvalid_o,
  input  logic        res_dready_i,
  output logic [7:0]  res_data_o,
  output logic        res_dlast_o
);
  logic [15:0] left_q;
  logic [1:0]  lane_q;
  logic [31:0] word_q;
  logic        len_xfer;
  logic        byte_xfer;
  logic        final_byte;
  logic        fetch;

  assign len_xfer   = res_valid_o & res_ready_i;
  assign byte_xfer  = res_dvalid_o & res_dready_i;
  // Last byte sits in the final word at lane (len - 1) mod 4
  assign final_byte = (left_q == '0) & (lane_q == (res_len_o[1:0] - 2'd1));
  // Also pulses once after the final byte so the sequencer can finish
  assign word_req_o = len_xfer | (byte_xfer & (final_byte | (lane_q == 2'd3)));
  assign fetch      = word_req_o & (left_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o  <= 1'b0;
      res_dvalid_o <= 1'b0;
      left_q       <= '0;
      lane_q       <= '0;
    end else begin
      if (load_i) begin
        res_valid_o <= 1'b1;
        left_q      <= words_i;
      end else if (len_xfer) begin
        res_valid_o <= 1'b0;
      end
      if (fetch) begin
        res_dvalid_o <= 1'b1;
        left_q       <= left_q - 16'd1;
        lane_q       <= '0;
      end else if (byte_xfer) begin
        if (final_byte) res_dvalid_o <= 1'b0;
        lane_q <= lane_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) res_len_o <= len_i;
    if (fetch) word_q <= rd_word_i;
  end

  // Least significant byte first
  assign res_data_o  = word_q[8*lane_q +: 8];
  assign res_dlast_o = res_dvalid_o & final_byte;

endmodule

/* hw/recovery_indirect_fifo.sv */
// Indirect payload FIFO with wrapping indices, word count, flags and clear
`timescale 1ns/100ps

module recovery_indirect_fifo #(
  parameter int unsigned FifoDepth = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push_i,
  input  logic [31:0]                  push_data_i,
  input  logic                         clr_i,
  output logic                         pop_valid_o,
  input  logic                         pop_ready_i,
  output logic [31:0]                  pop_data_o,
  output logic                         empty_o,
  output logic                         full_o,
  output logic [$clog2(FifoDepth)-1:0] wr_idx_o,
  output logic [$clog2(FifoDepth)-1:0] rd_idx_o
);
  localparam int unsigned IdxW = $clog2(FifoDepth);

  logic [31:0]   mem_q [FifoDepth];
  logic [IdxW:0] count_q;
  logic          do_push;
  logic          do_pop;

  assign do_push = push_i & ~full_o & ~clr_i;
  assign do_pop  = pop_valid_o & pop_ready_i & ~clr_i;

  // Indices wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_o <= '0;
      rd_idx_o <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_idx_o <= '0;
      rd_idx_o <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_idx_o <= wr_idx_o + 1'b1;
      if (do_pop) rd_idx_o <= rd_idx_o + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_idx_o] <= push_data_i;
    end
  end

  assign empty_o     = (count_q == '0);
  assign full_o      = (count_q == (IdxW + 1)'(FifoDepth));
  assign pop_valid_o = ~empty_o;
  assign pop_data_o  = mem_q[rd_idx_o];

endmodule

/* hw/recovery_reg_bank.sv */
// Recovery registers, protocol status, read mux, FIFO clear, image activation, payload flag
`timescale 1ns/100ps

module recovery_reg_bank #(
  parameter int unsigned FifoDepth = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  recovery_pkg::reg_e           reg_idx_i,
  input  logic                         reg_we_i,
  input  logic [31:0]                  wr_data_i,
  input  logic                         done_i,
  input  recovery_pkg::proto_err_e     done_status_i,
  input  logic                         fifo_written_i,
  input  logic                         fifo_pop_i,
  input  logic                         fifo_empty_i,
  input  logic                         fifo_full_i,
  input  logic [$clog2(FifoDepth)-1:0] fifo_wr_idx_i,
  input  logic [$clog2(FifoDepth)-1:0] fifo_rd_idx_i,
  output logic [31:0]                  rd_word_o,
  output logic                         fifo_clr_o,
  output logic                         payload_available_o,
  output logic                         image_activated_o
);
  import recovery_pkg::*;

  logic [31:0] dev_reset_q;
  logic [31:0] rec_ctrl_q;
  logic [31:0] fifo_ctrl_0_q;
  logic [31:0] fifo_ctrl_1_q;
  proto_err_e  proto_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_reset_q   <= '0;
      rec_ctrl_q    <= '0;
      fifo_ctrl_0_q <= '0;
      fifo_ctrl_1_q <= '0;
      proto_q       <= PROTO_OK;
    end else begin
      if (reg_we_i) begin
        case (reg_idx_i)
          REG_DEVICE_RESET:  dev_reset_q   <= wr_data_i;
          REG_RECOVERY_CTRL: rec_ctrl_q    <= wr_data_i;
          REG_FIFO_CTRL_0:   fifo_ctrl_0_q <= wr_data_i;
          REG_FIFO_CTRL_1:   fifo_ctrl_1_q <= wr_data_i;
          default: ;
        endcase
      end
      // Status of the finished command, seen by the next read
      if (done_i) proto_q <= done_status_i;
    end
  end

  // Reset request in FIFO_CTRL_0 byte 1
  assign fifo_clr_o = reg_we_i & (reg_idx_i == REG_FIFO_CTRL_0) & (wr_data_i[15:8] == 8'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      payload_available_o <= 1'b0;
    end else if (fifo_written_i) begin
      payload_available_o <= 1'b1;
    end else if (fifo_pop_i) begin
      payload_available_o <= 1'b0;
    end
  end

  assign image_activated_o = (rec_ctrl_q[23:16] == IMAGE_ACTIVATE);

  always_comb begin
    case (reg_idx_i)
      REG_DEVICE_STATUS: rd_word_o = {16'd0, proto_q, 8'd0};
      REG_DEVICE_RESET:  rd_word_o = dev_reset_q;
      REG_RECOVERY_CTRL: rd_word_o = rec_ctrl_q;
      REG_FIFO_CTRL_0:   rd_word_o = fifo_ctrl_0_q;
      REG_FIFO_CTRL_1:   rd_word_o = fifo_ctrl_1_q;
      REG_FIFO_STATUS_0: rd_word_o = {30'd0, fifo_full_i, fifo_empty_i};
      REG_FIFO_STATUS_1: rd_word_o = 32'(fifo_wr_idx_i);
      REG_FIFO_STATUS_2: rd_word_o = 32'(fifo_rd_idx_i);
      REG_FIFO_STATUS_3: rd_word_o = 32'(FifoDepth);
      default:           rd_word_o = '0;
    endcase
  end

endmodule

/* hw/recovery_sequencer.sv */
// Control FSM for write words, read word requests and command completion
`timescale 1ns/100ps

module recovery_sequencer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dec_valid_i,
  input  recovery_pkg::dec_t       dec_i,
  input  logic                     wr_valid_i,
  output logic                     wr_ready_o,
  input  logic                     fifo_full_i,
  input  logic                     word_req_i,
  output logic                     idle_o,
  output recovery_pkg::reg_e       reg_idx_o,
  output logic                     reg_we_o,
  output logic                     fifo_push_o,
  output logic                     tx_load_o,
  output logic [15:0]              tx_len_o,
  output logic [15:0]              tx_words_o,
  output logic                     done_o,
  output recovery_pkg::proto_err_e done_status_o,
  output logic                     fifo_written_o
);
  import recovery_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    DONE
  } state_e;

  state_e      state_q;
  state_e      state_d;
  op_e         op_q;
  reg_e        idx_q;
  logic [15:0] cnt_q;
  proto_err_e  status_q;
  logic        start;
  logic        wr_xfer;
  logic        step;

  assign start   = (state_q == IDLE) & dec_valid_i;
  assign wr_xfer = wr_valid_i & wr_ready_o;
  // One register word consumed, either written or fetched by the serializer
  assign step    = wr_xfer | ((state_q == READ) & word_req_i & (cnt_q != '0));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (dec_valid_i) begin
          if (dec_i.op == OP_CSR_READ) state_d = READ;
          else if (dec_i.op == OP_REJECT || dec_i.words == '0) state_d = DONE;
          else state_d = WRITE;
        end
      end
      WRITE: if (wr_xfer && cnt_q == 16'd1) state_d = DONE;
      // Request with no words left means the last byte went out
      READ: if (word_req_i && cnt_q == '0) state_d = DONE;
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      op_q    <= OP_CSR_WRITE;
      idx_q   <= REG_DEVICE_STATUS;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        op_q  <= dec_i.op;
        idx_q <= dec_i.base;
        cnt_q <= dec_i.words;
      end else if (step) begin
        cnt_q <= cnt_q - 16'd1;
        if (idx_q != REG_NONE) idx_q <= reg_e'(idx_q + 4'd1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      status_q <= dec_i.status;
    end
  end

  assign idle_o      = (state_q == IDLE);
  // FIFO writes wait while the FIFO is full
  assign wr_ready_o  = (state_q == WRITE) & ~((op_q == OP_FIFO_WRITE) & fifo_full_i);
  assign reg_idx_o   = idx_q;
  assign reg_we_o    = wr_xfer & (op_q == OP_CSR_WRITE);
  assign fifo_push_o = wr_xfer & (op_q == OP_FIFO_WRITE);

  assign tx_load_o  = start & (dec_i.op == OP_CSR_READ);
  assign tx_len_o   = dec_i.rd_len;
  assign tx_words_o = dec_i.words;

  assign done_o         = (state_q == DONE);
  assign done_status_o  = status_q;
  assign fifo_written_o = done_o & (op_q == OP_FIFO_WRITE);

endmodule

/* hw/recovery_cmd_decode.sv */
// Command acceptance, decoding rules, base register and byte length lookup
`timescale 1ns/100ps

module recovery_cmd_decode (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  input  recovery_pkg::cmd_t cmd_i,
  input  logic               idle_i,
  output logic               dec_valid_o,
  output recovery_pkg::dec_t dec_o
);
  import recovery_pkg::*;

  dec_t        dec_d;
  logic [15:0] byte_len;
  logic        known;
  logic        is_fifo_data;

  function automatic logic [15:0] to_words(logic [15:0] n);
    return (n >> 2) + 16'(|n[1:0]);
  endfunction

  // Sequencer stays idle during the hand-over cycle, so block a second accept there
  assign cmd_ready_o  = idle_i & ~dec_valid_o;
  assign is_fifo_data = (cmd_i.code == CMD_INDIRECT_FIFO_DATA);

  always_comb begin
    dec_d.base = REG_NONE;
    byte_len   = '0;
    case (cmd_i.code)
      CMD_DEVICE_STATUS:        dec_d.base = REG_DEVICE_STATUS;
      CMD_DEVICE_RESET:         dec_d.base = REG_DEVICE_RESET;
      CMD_RECOVERY_CTRL:        dec_d.base = REG_RECOVERY_CTRL;
      CMD_INDIRECT_FIFO_CTRL:   dec_d.base = REG_FIFO_CTRL_0;
      CMD_INDIRECT_FIFO_STATUS: dec_d.base = REG_FIFO_STATUS_0;
      default:                  dec_d.base = REG_NONE;
    endcase
    case (cmd_i.code)
      CMD_DEVICE_STATUS:        byte_len = LEN_DEVICE_STATUS;
      CMD_DEVICE_RESET:         byte_len = LEN_DEVICE_RESET;
      CMD_RECOVERY_CTRL:        byte_len = LEN_RECOVERY_CTRL;
      CMD_INDIRECT_FIFO_CTRL:   byte_len = LEN_FIFO_CTRL;
      CMD_INDIRECT_FIFO_STATUS: byte_len = LEN_FIFO_STATUS;
      default:                  byte_len = '0;
    endcase
    known = (dec_d.base != REG_NONE) | is_fifo_data;

    // Rules in priority order
    if (cmd_i.error) dec_d.status = PROTO_CRC;
    else if (!known) dec_d.status = PROTO_PARAMETER;
    else if (cmd_i.is_rd && is_fifo_data) dec_d.status = PROTO_PARAMETER;
    else if (!cmd_i.is_rd && (cmd_i.code == CMD_DEVICE_STATUS ||
                              cmd_i.code == CMD_INDIRECT_FIFO_STATUS)) begin
      dec_d.status = PROTO_READ_ONLY;
    end else if (!cmd_i.is_rd && !is_fifo_data && cmd_i.len > byte_len) begin
      dec_d.status = PROTO_LENGTH;
    end else dec_d.status = PROTO_OK;

    if (dec_d.status != PROTO_OK) dec_d.op = OP_REJECT;
    else if (cmd_i.is_rd) dec_d.op = OP_CSR_READ;
    else if (is_fifo_data) dec_d.op = OP_FIFO_WRITE;
    else dec_d.op = OP_CSR_WRITE;

    // Reads return the whole register, writes take what the host sends
    dec_d.rd_len = byte_len;
    if (dec_d.op == OP_REJECT) dec_d.words = '0;
    else if (cmd_i.is_rd) dec_d.words = to_words(byte_len);
    else dec_d.words = to_words(cmd_i.len);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= cmd_valid_i & cmd_ready_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      dec_o <= dec_d;
    end
  end

endmodule

/* hw/recovery_pkg.sv */
// Command, error, register and operation enums, command structs, register byte lengths
package recovery_pkg;

  // Recovery command codes kept by this target
  typedef enum logic [7:0] {
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } cmd_e;

  // Protocol error byte of DEVICE_STATUS
  typedef enum logic [7:0] {
    PROTO_OK        = 8'h0,
    PROTO_READ_ONLY = 8'h1,
    PROTO_PARAMETER = 8'h2,
    PROTO_LENGTH    = 8'h3,
    PROTO_CRC       = 8'h4
  } proto_err_e;

  // One index per 32-bit register word, multi-word registers are consecutive
  typedef enum logic [3:0] {
    REG_DEVICE_STATUS,
    REG_DEVICE_RESET,
    REG_RECOVERY_CTRL,
    REG_FIFO_CTRL_0,
    REG_FIFO_CTRL_1,
    REG_FIFO_STATUS_0,
    REG_FIFO_STATUS_1,
    REG_FIFO_STATUS_2,
    REG_FIFO_STATUS_3,
    REG_NONE
  } reg_e;

  typedef enum logic [1:0] {
    OP_CSR_WRITE,
    OP_CSR_READ,
    OP_FIFO_WRITE,
    OP_REJECT
  } op_e;

  typedef struct packed {
    logic        is_rd;
    cmd_e        code;
    logic [15:0] len;
    logic        error;
  } cmd_t;

  typedef struct packed {
    op_e         op;
    reg_e        base;
    logic [15:0] words;
    logic [15:0] rd_len;
    proto_err_e  status;
  } dec_t;

  // Register sizes in bytes
  localparam logic [15:0] LEN_DEVICE_STATUS = 16'd4;
  localparam logic [15:0] LEN_DEVICE_RESET  = 16'd3;
  localparam logic [15:0] LEN_RECOVERY_CTRL = 16'd3;
  localparam logic [15:0] LEN_FIFO_CTRL     = 16'd6;
  localparam logic [15:0] LEN_FIFO_STATUS   = 16'd16;

  localparam logic [7:0] IMAGE_ACTIVATE = 8'h0F;

endpackage
